// File: tb/pwo_vectors.hex
// op _ accumulate _ word index _ A _ B _ C _ expected, 400 bits per line
// Each word is slot3 slot2 slot1 slot0, 6 hex digits per slot (pad bit on top)
0_0_00_7FE0007FE000001000000001_7FE000000001000100000002_123456123456123456123456_0000017FE000100000000002
0_0_01_7FE0007FE000002000000002_7FE000000002000100000003_123456123456123456123456_0000017FDFFF200000000006
0_0_02_7FE0007FE000003000000003_7FE000000003000100000004_123456123456123456123456_0000017FDFFE30000000000C
0_0_03_7FE0007FE000004000000004_7FE000000004000100000005_123456123456123456123456_0000017FDFFD400000000014
0_0_04_7FE0007FE000005000000005_7FE000000005000100000006_123456123456123456123456_0000017FDFFC50000000001E
0_0_05_7FE0007FE000006000000006_7FE000000006000100000007_123456123456123456123456_0000017FDFFB60000000002A
0_0_06_7FE0007FE000007000000007_7FE000000007000100000008_123456123456123456123456_0000017FDFFA700000000038
0_0_07_7FE0007FE000008000000008_7FE000000008000100000009_123456123456123456123456_0000017FDFF9001FFF000048
0_1_00_7FE0007FE000001000000001_7FE000000001000100000002_0000050000017FE000000010_0000060000000FFFFF000012
0_1_01_7FE0007FE000002000000002_7FE000000002000100000003_0000050000027FE000000010_0000060000001FFFFF000016
0_1_02_7FE0007FE000003000000003_7FE000000003000100000004_0000050000037FE000000010_0000060000002FFFFF00001C
0_1_03_7FE0007FE000004000000004_7FE000000004000100000005_0000050000047FE000000010_0000060000003FFFFF000024
0_1_04_7FE0007FE000005000000005_7FE000000005000100000006_0000050000057FE000000010_0000060000004FFFFF00002E
0_1_05_7FE0007FE000006000000006_7FE000000006000100000007_0000050000067FE000000010_0000060000005FFFFF00003A
0_1_06_7FE0007FE000007000000007_7FE000000007000100000008_0000050000077FE000000010_0000060000006FFFFF000048
0_1_07_7FE0007FE000008000000008_7FE000000008000100000009_0000050000087FE000000010_000006000000001FFE000058
1_1_00_0000004000007FE000000000_000000400000000001000010_0AAAAA0AAAAA0AAAAA0AAAAA_000000001FFF000000000010
1_1_01_0000004000007FE000000001_000000400000000002000010_0AAAAA0AAAAA0AAAAA0AAAAA_000000001FFF000001000011
1_1_02_0000004000007FE000000002_000000400000000003000010_0AAAAA0AAAAA0AAAAA0AAAAA_000000001FFF000002000012
1_1_03_0000004000007FE000000003_000000400000000004000010_0AAAAA0AAAAA0AAAAA0AAAAA_000000001FFF000003000013
1_1_04_0000004000007FE000000004_000000400000000005000010_0AAAAA0AAAAA0AAAAA0AAAAA_000000001FFF000004000014
1_1_05_0000004000007FE000000005_000000400000000006000010_0AAAAA0AAAAA0AAAAA0AAAAA_000000001FFF000005000015
1_1_06_0000004000007FE000000006_000000400000000007000010_0AAAAA0AAAAA0AAAAA0AAAAA_000000001FFF000006000016
1_1_07_0000004000007FE000000007_000000400000000008000010_0AAAAA0AAAAA0AAAAA0AAAAA_000000001FFF000007000017
2_0_00_FFE000000000000000000100_000000000001000001000000_055555055555055555055555_7FE0007FE0007FE000000100
2_0_01_FFE000000000000001000100_000000000002000002000001_055555055555055555055555_7FE0007FDFFF7FE0000000FF
2_0_02_FFE000000000000002000100_000000000003000003000002_055555055555055555055555_7FE0007FDFFE7FE0000000FE
2_0_03_FFE000000000000003000100_000000000004000004000003_055555055555055555055555_7FE0007FDFFD7FE0000000FD
2_0_04_FFE000000000000004000100_000000000005000005000004_055555055555055555055555_7FE0007FDFFC7FE0000000FC
2_0_05_FFE000000000000005000100_000000000006000006000005_055555055555055555055555_7FE0007FDFFB7FE0000000FB
2_0_06_FFE000000000000006000100_000000000007000007000006_055555055555055555055555_7FE0007FDFFA7FE0000000FA
2_0_07_FFE000000000000007000100_000000000008000008000007_055555055555055555055555_7FE0007FDFF97FE0000000F9

// File: compile.f
verilog/pwo_pkg.sv
verilog/pwo_ctrl.sv
verilog/pwo_lane.sv
verilog/pwo_writeback.sv
verilog/pwo_top.sv
tb/pwo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the pointwise engine testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -Wno-fatal \
    -f compile.f --top-module pwo_tb -Mdir obj_dir -o pwo_sim

./obj_dir/pwo_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

// File: tb/pwo_tb.sv
`timescale 1ns/1ps
// ==========================================================================
// Testbench for the pointwise engine. Loads A, B and C memories from the
// vector file, runs pwm, pwm with accumulate, pwa and pws passes, a pass cut
// off by zeroize, and checks results, request timing and the done pulse
// ==========================================================================

module pwo_tb
    import pwo_pkg::*;
();

    localparam int POLY_WORDS = 8;
    localparam int NUM_TESTS  = 4;
    localparam int VEC_W      = 400;
    localparam int WAIT_LIMIT = 200;
    localparam mem_req_t IDLE_REQ = '{rw: rw_idle, addr: '0};

    logic                  clk;
    logic                  reset_n;
    logic                  zeroize_i;
    logic                  start_i;
    pwo_op_e               op_i;
    logic                  accumulate_i;
    logic [MEM_ADDR_W-1:0] a_base_i;
    logic [MEM_ADDR_W-1:0] b_base_i;
    logic [MEM_ADDR_W-1:0] c_base_i;
    poly_word_t            a_rd_data_i;
    poly_word_t            b_rd_data_i;
    poly_word_t            c_rd_data_i;
    mem_req_t              a_rd_req_o;
    mem_req_t              b_rd_req_o;
    mem_req_t              c_rd_req_o;
    mem_req_t              c_wr_req_o;
    poly_word_t            c_wr_data_o;
    logic                  busy_o;
    logic                  done_o;

    poly_word_t       a_mem [0:(1<<MEM_ADDR_W)-1];
    poly_word_t       b_mem [0:(1<<MEM_ADDR_W)-1];
    poly_word_t       c_mem [0:(1<<MEM_ADDR_W)-1];
    logic [VEC_W-1:0] vec_mem [0:NUM_TESTS*POLY_WORDS-1];
    poly_word_t       exp_word [POLY_WORDS];

    mem_req_t              a_pend;
    mem_req_t              b_pend;
    mem_req_t              c_pend;
    pwo_op_e               cur_op;
    logic                  cur_acc;
    logic [MEM_ADDR_W-1:0] cur_a_base;
    logic [MEM_ADDR_W-1:0] cur_b_base;
    logic [MEM_ADDR_W-1:0] cur_c_base;

    int   cyc = 0;
    int   start_cyc;
    int   rd_cyc [POLY_WORDS];
    int   wr_cyc [POLY_WORDS];
    int   c_rd_cnt [POLY_WORDS];
    int   wr_cnt;
    int   done_cnt;
    int   done_cyc;
    int   errors;
    int   tests_run;
    int   tests_failed;
    logic timed_out;
    logic busy_prev;

    pwo_top #(
        .POLY_WORDS(POLY_WORDS)
    ) u_pwo_top (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .start_i     (start_i),
        .op_i        (op_i),
        .accumulate_i(accumulate_i),
        .a_base_i    (a_base_i),
        .b_base_i    (b_base_i),
        .c_base_i    (c_base_i),
        .a_rd_data_i (a_rd_data_i),
        .b_rd_data_i (b_rd_data_i),
        .c_rd_data_i (c_rd_data_i),
        .a_rd_req_o  (a_rd_req_o),
        .b_rd_req_o  (b_rd_req_o),
        .c_rd_req_o  (c_rd_req_o),
        .c_wr_req_o  (c_wr_req_o),
        .c_wr_data_o (c_wr_data_o),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ======================================================================
    // Compare tasks
    // ======================================================================

    task automatic check_word(input poly_word_t got, input poly_word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAILED at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // ======================================================================
    // Memory models and monitor, all on the falling edge
    // ======================================================================

    always @(negedge clk) begin : mem_model
        int k;
        // Read data answers the request of the previous cycle
        if (a_pend.rw == rw_read) a_rd_data_i = a_mem[a_pend.addr];
        if (b_pend.rw == rw_read) b_rd_data_i = b_mem[b_pend.addr];
        if (c_pend.rw == rw_read) c_rd_data_i = c_mem[c_pend.addr];
        a_pend = a_rd_req_o;
        b_pend = b_rd_req_o;
        c_pend = c_rd_req_o;
        if (a_rd_req_o.rw == rw_read) begin
            k = int'(a_rd_req_o.addr) - int'(cur_a_base);
            if (k >= 0 && k < POLY_WORDS) rd_cyc[k] = cyc;
        end
        if (c_rd_req_o.rw == rw_read) begin
            k = int'(c_rd_req_o.addr) - int'(cur_c_base);
            if (k >= 0 && k < POLY_WORDS) c_rd_cnt[k]++;
        end
        if (c_wr_req_o.rw == rw_write) begin
            k = int'(c_wr_req_o.addr) - int'(cur_c_base);
            c_mem[c_wr_req_o.addr] = c_wr_data_o;
            wr_cnt++;
            if (k >= 0 && k < POLY_WORDS) begin
                wr_cyc[k] = cyc;
            end else begin
                $display("Write to address %h lies outside the C region", c_wr_req_o.addr);
                errors++;
            end
        end
        if (done_o) begin
            done_cnt++;
            done_cyc = cyc;
            check_flag(busy_o, 1'b0, "busy_o low with done_o");
            check_flag(busy_prev, 1'b1, "busy_o high before done_o");
        end
        busy_prev = busy_o;
    end

    // ======================================================================
    // Pass helpers
    // ======================================================================

    task automatic load_test(input int t, input logic [MEM_ADDR_W-1:0] c_base);
        logic [VEC_W-1:0] v;
        int k;
        cur_a_base = MEM_ADDR_W'(15'h100 + t * 15'h20);
        cur_b_base = MEM_ADDR_W'(15'h200 + t * 15'h20);
        cur_c_base = c_base;
        for (int i = 0; i < POLY_WORDS; i++) begin
            v = vec_mem[t * POLY_WORDS + i];
            k = int'(v[391:384]);
            cur_op  = pwo_op_e'(v[397:396]);
            cur_acc = v[392];
            a_mem[cur_a_base + k] = v[383:288];
            b_mem[cur_b_base + k] = v[287:192];
            c_mem[cur_c_base + k] = v[191:96];
            exp_word[k] = v[95:0];
        end
    endtask

    task automatic clear_counts();
        for (int k = 0; k < POLY_WORDS; k++) begin
            rd_cyc[k]   = -1;
            wr_cyc[k]   = -1;
            c_rd_cnt[k] = 0;
        end
        wr_cnt   = 0;
        done_cnt = 0;
    endtask

    task automatic start_pass();
        op_i         = cur_op;
        accumulate_i = cur_acc;
        a_base_i     = cur_a_base;
        b_base_i     = cur_b_base;
        c_base_i     = cur_c_base;
        start_i      = 1'b1;
        start_cyc    = cyc;
        @(negedge clk);
        start_i = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done_cnt == 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (done_cnt == 0) begin
            $display("Timeout: done_o did not pulse within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end else begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors != err0 || timed_out) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
    endtask

    task automatic run_test(input int t, input string name, input logic [MEM_ADDR_W-1:0] c_base);
        int err0;
        int c_reads;
        err0 = errors;
        load_test(t, c_base);
        clear_counts();
        start_pass();
        wait_done();
        if (!timed_out) begin
            // A few idle cycles to catch a second done or stray writes
            repeat (3) @(negedge clk);
            c_reads = (cur_acc && cur_op == op_pwm) ? 1 : 0;
            check_count(done_cnt, 1, "done_o pulse count");
            check_count(done_cyc - start_cyc, POLY_WORDS + 7, "start to done cycles");
            check_count(rd_cyc[0] - start_cyc, 1, "start to first read cycles");
            check_count(wr_cnt, POLY_WORDS, "write count");
            for (int k = 0; k < POLY_WORDS; k++) begin
                check_word(c_mem[cur_c_base + k], exp_word[k],
                           $sformatf("%s word %0d", name, k));
                check_count(wr_cyc[k] - rd_cyc[k], 6, $sformatf("read to write word %0d", k));
                check_count(c_rd_cnt[k], c_reads, $sformatf("C reads of word %0d", k));
            end
        end
        report_test(name, err0);
    endtask

    task automatic run_zeroize();
        int err0;
        int n;
        int wr_before;
        err0 = errors;
        load_test(2, 15'h320);
        clear_counts();
        start_pass();
        n = 0;
        // Cut the pass in the first write cycle, while reads are still issued
        while (c_wr_req_o.rw != rw_write && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (c_wr_req_o.rw != rw_write) begin
            $display("Timeout: no write seen within %0d cycles before zeroize", WAIT_LIMIT);
            timed_out = 1'b1;
        end else begin
            zeroize_i = 1'b1;
            @(negedge clk);
            zeroize_i = 1'b0;
            check_req(a_rd_req_o, IDLE_REQ, "A read request after zeroize");
            check_req(b_rd_req_o, IDLE_REQ, "B read request after zeroize");
            check_req(c_rd_req_o, IDLE_REQ, "C read request after zeroize");
            check_req(c_wr_req_o, IDLE_REQ, "C write request after zeroize");
            check_flag(busy_o, 1'b0, "busy_o after zeroize");
            check_flag(done_o, 1'b0, "done_o after zeroize");
            wr_before = wr_cnt;
            repeat (2 * POLY_WORDS + 10) @(negedge clk);
            check_count(wr_cnt, wr_before, "writes after zeroize");
            check_count(done_cnt, 0, "done_o pulses after zeroize");
        end
        report_test("zeroize during pwa", err0);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        reset_n      = 1'b0;
        zeroize_i    = 1'b0;
        start_i      = 1'b0;
        op_i         = op_pwm;
        accumulate_i = 1'b0;
        a_base_i     = '0;
        b_base_i     = '0;
        c_base_i     = '0;
        a_rd_data_i  = '0;
        b_rd_data_i  = '0;
        c_rd_data_i  = '0;
        a_pend       = IDLE_REQ;
        b_pend       = IDLE_REQ;
        c_pend       = IDLE_REQ;
        cur_a_base   = '0;
        cur_b_base   = '0;
        cur_c_base   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        busy_prev    = 1'b0;
        clear_counts();
        $readmemh("tb/pwo_vectors.hex", vec_mem);
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_req(a_rd_req_o, IDLE_REQ, "A read request after reset");
        check_req(b_rd_req_o, IDLE_REQ, "B read request after reset");
        check_req(c_rd_req_o, IDLE_REQ, "C read request after reset");
        check_req(c_wr_req_o, IDLE_REQ, "C write request after reset");
        check_flag(busy_o, 1'b0, "busy_o after reset");
        check_flag(done_o, 1'b0, "done_o after reset");

        run_test(0, "pwm", 15'h300);
        if (!timed_out) run_test(1, "pwm accumulate", 15'h308);
        if (!timed_out) run_test(2, "pwa", 15'h310);
        if (!timed_out) run_test(3, "pws", 15'h318);
        if (!timed_out) run_zeroize();
        if (!timed_out) run_test(2, "pwa after zeroize", 15'h328);

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/pwo_top.sv
`timescale 1ns/1ps
// ==========================================================================
// Top level of the pointwise engine. The controller reads A, B and C, four
// lanes work on the slots of each word and the write-back stores C
// ==========================================================================

module pwo_top
    import pwo_pkg::*;
#(
    parameter int POLY_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  start_i,
    input  pwo_op_e               op_i,
    input  logic                  accumulate_i,
    input  logic [MEM_ADDR_W-1:0] a_base_i,
    input  logic [MEM_ADDR_W-1:0] b_base_i,
    input  logic [MEM_ADDR_W-1:0] c_base_i,
    input  poly_word_t            a_rd_data_i,
    input  poly_word_t            b_rd_data_i,
    input  poly_word_t            c_rd_data_i,
    output mem_req_t              a_rd_req_o,
    output mem_req_t              b_rd_req_o,
    output mem_req_t              c_rd_req_o,
    output mem_req_t              c_wr_req_o,
    output poly_word_t            c_wr_data_o,
    output logic                  busy_o,
    output logic                  done_o
);

    pwo_cmd_t           cmd;
    logic               operand_valid;
    coeff_t [LANES-1:0] lane_coeff;
    logic [LANES-1:0]   lane_valid;
    poly_word_t         lane_result;

    pwo_ctrl #(
        .POLY_WORDS(POLY_WORDS)
    ) u_pwo_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize_i      (zeroize_i),
        .start_i        (start_i),
        .op_i           (op_i),
        .accumulate_i   (accumulate_i),
        .a_base_i       (a_base_i),
        .b_base_i       (b_base_i),
        .c_base_i       (c_base_i),
        .done_i         (done_o),
        .a_rd_req_o     (a_rd_req_o),
        .b_rd_req_o     (b_rd_req_o),
        .c_rd_req_o     (c_rd_req_o),
        .cmd_o          (cmd),
        .operand_valid_o(operand_valid),
        .busy_o         (busy_o)
    );

    // ======================================================================
    // Coefficient lanes, one per slot of the memory word
    // ======================================================================

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        pwo_lane u_pwo_lane (
            .clk            (clk),
            .reset_n        (reset_n),
            .zeroize_i      (zeroize_i),
            .cmd_i          (cmd),
            .operand_valid_i(operand_valid),
            .a_i            (a_rd_data_i.slot[g].coeff),
            .b_i            (b_rd_data_i.slot[g].coeff),
            .c_i            (c_rd_data_i.slot[g].coeff),
            .result_o       (lane_coeff[g]),
            .result_valid_o (lane_valid[g])
        );
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_result.slot[i].pad   = 1'b0;
            lane_result.slot[i].coeff = lane_coeff[i];
        end
    end

    pwo_writeback #(
        .POLY_WORDS(POLY_WORDS)
    ) u_pwo_writeback (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize_i      (zeroize_i),
        .c_base_i       (c_base_i),
        .operand_valid_i(operand_valid),
        .lane_valid_i   (lane_valid),
        .lane_result_i  (lane_result),
        .c_wr_req_o     (c_wr_req_o),
        .c_wr_data_o    (c_wr_data_o),
        .done_o         (done_o)
    );

endmodule

// File: verilog/pwo_writeback.sv
`timescale 1ns/1ps
// ==========================================================================
// Write-back for the pointwise engine. Packs the lane results into one
// memory word, aligns the C write request and pulses done after the
// last word of the pass
// ==========================================================================

module pwo_writeback
    import pwo_pkg::*;
#(
    parameter int POLY_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic [MEM_ADDR_W-1:0] c_base_i,
    input  logic                  operand_valid_i,
    input  logic [LANES-1:0]      lane_valid_i,
    input  poly_word_t            lane_result_i,
    output mem_req_t              c_wr_req_o,
    output poly_word_t            c_wr_data_o,
    output logic                  done_o
);

    localparam int CNT_W = (POLY_WORDS > 1) ? $clog2(POLY_WORDS) : 1;

    logic                  accept;
    logic                  last_word;
    logic [CNT_W-1:0]      word_cnt_q;
    logic                  wr_valid_q;
    logic                  wr_last_q;
    logic [MEM_ADDR_W-1:0] wr_addr_q;
    poly_word_t            wr_data_q;
    poly_word_t            packed_word;

    // All lanes run in lock step
    assign accept    = &lane_valid_i;
    assign last_word = (word_cnt_q == CNT_W'(POLY_WORDS - 1));

    // Memory format keeps the pad bit of every slot at zero
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            packed_word.slot[i].pad   = 1'b0;
            packed_word.slot[i].coeff = lane_result_i.slot[i].coeff;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            word_cnt_q <= '0;
            wr_valid_q <= 1'b0;
            wr_last_q  <= 1'b0;
            done_o     <= 1'b0;
        end else if (zeroize_i) begin
            word_cnt_q <= '0;
            wr_valid_q <= 1'b0;
            wr_last_q  <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            wr_valid_q <= accept;
            wr_last_q  <= accept & last_word;
            // Done follows the cycle of the last write
            done_o     <= wr_last_q;
            if (accept) begin
                word_cnt_q <= last_word ? '0 : word_cnt_q + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr_q <= c_base_i + MEM_ADDR_W'(word_cnt_q);
            wr_data_q <= packed_word;
        end
    end

    assign c_wr_req_o.rw   = wr_valid_q ? rw_write : rw_idle;
    assign c_wr_req_o.addr = wr_valid_q ? wr_addr_q : '0;
    assign c_wr_data_o     = wr_data_q;

    // Lane latency is four cycles unless a zeroize cuts the word off
    assert property (@(posedge clk) disable iff (!reset_n)
        (operand_valid_i && !zeroize_i) ##1 (!zeroize_i)[*3] |=> (&lane_valid_i));

    assert property (@(posedge clk) disable iff (!reset_n)
        (|lane_valid_i) |-> ((&lane_valid_i) && $past(operand_valid_i, 4)));

endmodule

// File: verilog/pwo_lane.sv
`timescale 1ns/1ps
// ==========================================================================
// One coefficient lane. Modular multiply, add or subtract mod q with an
// optional accumulate of C, in a fixed four-stage pipeline
// ==========================================================================

module pwo_lane
    import pwo_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     zeroize_i,
    input  pwo_cmd_t cmd_i,
    input  logic     operand_valid_i,
    input  coeff_t   a_i,
    input  coeff_t   b_i,
    input  coeff_t   c_i,
    output coeff_t   result_o,
    output logic     result_valid_o
);

    localparam int PROD_W  = 2 * COEFF_W;
    // 2^23 folds back as 2^13 - 1
    localparam int FOLD_SH = 13;
    localparam logic [SLOT_W-1:0] Q_EXT = SLOT_W'(PWO_Q);

    coeff_t            a_s1;
    coeff_t            b_s1;
    coeff_t            c_s1;
    logic              v_s1;
    logic [PROD_W-1:0] x_s2;
    coeff_t            c_s2;
    logic              v_s2;
    logic [SLOT_W-1:0] w_s3;
    coeff_t            c_s3;
    logic              v_s3;

    logic [PROD_W-1:0] x_d;
    logic [36:0]       fold1;
    logic [27:0]       fold2;
    logic [SLOT_W-1:0] fold3;
    logic [SLOT_W-1:0] red;
    logic [SLOT_W-1:0] acc_sum;
    logic [SLOT_W-1:0] res_d;

    // Stage 2 selects the raw value, all below q^2
    always_comb begin
        case (cmd_i.op)
            op_pwa:  x_d = PROD_W'(a_s1) + PROD_W'(b_s1);
            op_pws:  x_d = PROD_W'(a_s1) + PROD_W'(PWO_Q) - PROD_W'(b_s1);
            default: x_d = PROD_W'(a_s1) * PROD_W'(b_s1);
        endcase
    end

    // Stage 3 folds three times, the result ends below 2q
    always_comb begin
        fold1 = 37'(x_s2[COEFF_W-1:0])
              + (37'(x_s2[PROD_W-1:COEFF_W]) << FOLD_SH)
              - 37'(x_s2[PROD_W-1:COEFF_W]);
        fold2 = 28'(fold1[COEFF_W-1:0])
              + (28'(fold1[36:COEFF_W]) << FOLD_SH)
              - 28'(fold1[36:COEFF_W]);
        fold3 = SLOT_W'(fold2[COEFF_W-1:0])
              + (SLOT_W'(fold2[27:COEFF_W]) << FOLD_SH)
              - SLOT_W'(fold2[27:COEFF_W]);
    end

    // Stage 4 final correction, then accumulate and correct again
    always_comb begin
        red     = (w_s3 >= Q_EXT) ? w_s3 - Q_EXT : w_s3;
        acc_sum = red + (cmd_i.accumulate ? SLOT_W'(c_s3) : '0);
        res_d   = (acc_sum >= Q_EXT) ? acc_sum - Q_EXT : acc_sum;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            v_s1           <= 1'b0;
            v_s2           <= 1'b0;
            v_s3           <= 1'b0;
            result_valid_o <= 1'b0;
        end else if (zeroize_i) begin
            v_s1           <= 1'b0;
            v_s2           <= 1'b0;
            v_s3           <= 1'b0;
            result_valid_o <= 1'b0;
        end else begin
            v_s1           <= operand_valid_i;
            v_s2           <= v_s1;
            v_s3           <= v_s2;
            result_valid_o <= v_s3;
        end
    end

    // Data path, C rides along with its word
    always_ff @(posedge clk) begin
        a_s1     <= a_i;
        b_s1     <= b_i;
        c_s1     <= c_i;
        x_s2     <= x_d;
        c_s2     <= c_s1;
        w_s3     <= fold3;
        c_s3     <= c_s2;
        result_o <= res_d[COEFF_W-1:0];
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        result_valid_o |-> (result_o < PWO_Q));

endmodule

// File: verilog/pwo_ctrl.sv
`timescale 1ns/1ps
// ==========================================================================
// Pass controller for the pointwise engine. Latches the command on start,
// walks the word counter and issues one read per cycle to A, B and, for an
// accumulating multiply, C. operand_valid_o marks the returned read data
// ==========================================================================

module pwo_ctrl
    import pwo_pkg::*;
#(
    parameter int POLY_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  start_i,
    input  pwo_op_e               op_i,
    input  logic                  accumulate_i,
    input  logic [MEM_ADDR_W-1:0] a_base_i,
    input  logic [MEM_ADDR_W-1:0] b_base_i,
    input  logic [MEM_ADDR_W-1:0] c_base_i,
    input  logic                  done_i,
    output mem_req_t              a_rd_req_o,
    output mem_req_t              b_rd_req_o,
    output mem_req_t              c_rd_req_o,
    output pwo_cmd_t              cmd_o,
    output logic                  operand_valid_o,
    output logic                  busy_o
);

    localparam int CNT_W = (POLY_WORDS > 1) ? $clog2(POLY_WORDS) : 1;

    logic                  busy_q;
    logic                  rd_active_q;
    logic [CNT_W-1:0]      word_cnt_q;
    pwo_cmd_t              cmd_q;
    logic [MEM_ADDR_W-1:0] a_base_q;
    logic [MEM_ADDR_W-1:0] b_base_q;
    logic [MEM_ADDR_W-1:0] c_base_q;
    logic                  start_ok;
    logic                  last_word;
    logic [MEM_ADDR_W-1:0] offset;

    function automatic mem_req_t make_rd_req(input logic en,
                                             input logic [MEM_ADDR_W-1:0] addr);
        mem_req_t req;
        req.rw   = en ? rw_read : rw_idle;
        req.addr = en ? addr : '0;
        return req;
    endfunction

    // Busy drops together with the done pulse from the write-back
    assign busy_o    = busy_q & ~done_i;
    assign start_ok  = start_i & ~busy_o;
    assign last_word = (word_cnt_q == CNT_W'(POLY_WORDS - 1));
    assign offset    = MEM_ADDR_W'(word_cnt_q);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q          <= 1'b0;
            rd_active_q     <= 1'b0;
            word_cnt_q      <= '0;
            operand_valid_o <= 1'b0;
            cmd_q           <= '0;
            a_base_q        <= '0;
            b_base_q        <= '0;
            c_base_q        <= '0;
        end else if (zeroize_i) begin
            busy_q          <= 1'b0;
            rd_active_q     <= 1'b0;
            word_cnt_q      <= '0;
            operand_valid_o <= 1'b0;
            cmd_q           <= '0;
            a_base_q        <= '0;
            b_base_q        <= '0;
            c_base_q        <= '0;
        end else begin
            // Read data comes back one cycle after the request
            operand_valid_o <= rd_active_q;
            if (start_ok) begin
                busy_q           <= 1'b1;
                rd_active_q      <= 1'b1;
                word_cnt_q       <= '0;
                cmd_q.op         <= op_i;
                // Only pwm can accumulate into C
                cmd_q.accumulate <= accumulate_i & (op_i == op_pwm);
                a_base_q         <= a_base_i;
                b_base_q         <= b_base_i;
                c_base_q         <= c_base_i;
            end else begin
                if (done_i) begin
                    busy_q <= 1'b0;
                end
                if (rd_active_q) begin
                    word_cnt_q <= last_word ? '0 : word_cnt_q + CNT_W'(1);
                    if (last_word) begin
                        rd_active_q <= 1'b0;
                    end
                end
            end
        end
    end

    assign a_rd_req_o = make_rd_req(rd_active_q, a_base_q + offset);
    assign b_rd_req_o = make_rd_req(rd_active_q, b_base_q + offset);
    assign c_rd_req_o = make_rd_req(rd_active_q & cmd_q.accumulate, c_base_q + offset);
    assign cmd_o      = cmd_q;

    // Reads only while a pass is open, never past the write-back done
    assert property (@(posedge clk) disable iff (!reset_n)
        (a_rd_req_o.rw == rw_read) |-> busy_o);

    // C is untouched by pwa and pws passes
    assert property (@(posedge clk) disable iff (!reset_n)
        (c_rd_req_o.rw == rw_read) |-> (cmd_o.op == op_pwm));

endmodule

// File: verilog/pwo_pkg.sv
// ==========================================================================
// Shared definitions for the pointwise polynomial engine: field constants,
// coefficient and memory word types, memory request and command structs.
// Modules pull these in with a wildcard import in their header
// ==========================================================================

package pwo_pkg;

    // ======================================================================
    // Field and memory constants
    // ======================================================================

    // q = 2^23 - 2^13 + 1
    localparam int unsigned PWO_Q = 8380417;

    localparam int COEFF_W    = 23;
    // One zero pad bit above each coefficient
    localparam int SLOT_W     = 24;
    localparam int LANES      = 4;
    localparam int MEM_ADDR_W = 15;

    // ======================================================================
    // Data types
    // ======================================================================

    typedef logic [COEFF_W-1:0] coeff_t;

    typedef struct packed {
        logic   pad;
        coeff_t coeff;
    } poly_slot_t;

    // Slot 0 sits in the low bits of the memory word
    typedef struct packed {
        poly_slot_t [LANES-1:0] slot;
    } poly_word_t;

    typedef enum logic [1:0] {
        op_pwm,
        op_pwa,
        op_pws
    } pwo_op_e;

    typedef enum logic [1:0] {
        rw_idle,
        rw_read,
        rw_write
    } rw_e;

    typedef struct packed {
        rw_e                   rw;
        logic [MEM_ADDR_W-1:0] addr;
    } mem_req_t;

    // Command held for the length of one pass
    typedef struct packed {
        pwo_op_e op;
        logic    accumulate;
    } pwo_cmd_t;

endpackage
